// File: hdl/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data path
`define CPU_WORD_W 32

// word addressed memory space
`define CPU_ADDR_W 12

// register file
`define CPU_REG_CNT 16
`define CPU_REG_IDX_W 4

// first fetch after reset, words 0 to 2 are left free for data
`define CPU_RESET_PC 3

`endif

// File: hdl/cpu_pkg.sv
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [`CPU_WORD_W-1:0] word_t;
    typedef logic [`CPU_ADDR_W-1:0] addr_t;
    typedef logic [`CPU_REG_IDX_W-1:0] reg_idx_t;

    // codes 10 to 15 decode as nop
    typedef enum logic [3:0] {
        op_nop = 4'd0,
        op_ld  = 4'd1,
        op_str = 4'd2,
        op_bra = 4'd3,
        op_xor = 4'd4,
        op_add = 4'd5,
        op_rot = 4'd6,
        op_shf = 4'd7,
        op_hlt = 4'd8,
        op_cmp = 4'd9
    } opcode_e;

    // codes 8 to 15 never branch
    typedef enum logic [3:0] {
        cond_always   = 4'd0,
        cond_parity   = 4'd1,
        cond_even     = 4'd2,
        cond_carry    = 4'd3,
        cond_negative = 4'd4,
        cond_zero     = 4'd5,
        cond_no_carry = 4'd6,
        cond_positive = 4'd7
    } cond_e;

    typedef enum logic [2:0] {
        st_restart,
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback,
        st_halted
    } stage_e;

    typedef struct packed {
        opcode_e opcode;
        cond_e   cond;     // bit 3 imm op1, bit 2 zero op2 outside bra
        addr_t   addr_hi;  // imm, load addr, branch target, src reg
        addr_t   addr_lo;  // store addr, dest reg
    } instr_t;

    typedef struct packed {
        logic  en;
        logic  write;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic zero;
        logic negative;
        logic even;
        logic parity;
        logic carry;
    } flags_t;

    // ops that update result and carry and write back
    function automatic logic is_alu_op(opcode_e op);
        logic alu;
        case (op)
            op_xor, op_add, op_rot, op_shf, op_cmp: alu = 1'b1;
            default: alu = 1'b0;
        endcase
        return alu;
    endfunction

endpackage

`default_nettype wire

// File: hdl/cpu_regfile.sv
`default_nettype none

`include "cpu_settings.svh"

module cpu_regfile (
    input  wire logic              clk,
    input  wire logic              wr_en,
    input  wire cpu_pkg::reg_idx_t wr_idx,
    input  wire cpu_pkg::word_t    wr_data,
    input  wire cpu_pkg::reg_idx_t rd_idx_a,
    input  wire cpu_pkg::reg_idx_t rd_idx_b,
    output cpu_pkg::word_t         rd_data_a,
    output cpu_pkg::word_t         rd_data_b
);

    cpu_pkg::word_t regs [`CPU_REG_CNT];

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rd_data_a = regs[rd_idx_a];
    assign rd_data_b = regs[rd_idx_b];

endmodule

`default_nettype wire

// File: hdl/cpu_alu.sv
`default_nettype none

`include "cpu_settings.svh"

module cpu_alu (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             exec_strobe,
    input  wire cpu_pkg::opcode_e opcode,
    input  wire cpu_pkg::word_t   op1,
    input  wire cpu_pkg::word_t   op2,
    output cpu_pkg::word_t        result,
    output logic                  carry
);

    logic [3:0]              amt;
    logic                    left;
    logic [`CPU_WORD_W:0]    sum;
    logic [`CPU_WORD_W:0]    shl;
    logic [2*`CPU_WORD_W-1:0] rot_l;
    logic [2*`CPU_WORD_W-1:0] rot_r;
    cpu_pkg::word_t          res_next;
    logic                    carry_next;

    always_comb
    begin
        amt   = op1[3:0];
        left  = op1[4];
        sum   = {1'b0, op1} + {1'b0, op2};
        shl   = {1'b0, op2} << amt;         // top bit is the last one shifted out
        rot_l = {op2, op2} << amt;
        rot_r = {op2, op2} >> amt;

        res_next   = '0;
        carry_next = 1'b0;
        case (opcode)
            cpu_pkg::op_xor: res_next = op1 ^ op2;
            cpu_pkg::op_add: {carry_next, res_next} = sum;
            cpu_pkg::op_cmp: res_next = ~op1 + 1'b1;
            cpu_pkg::op_rot: res_next = left ? rot_l[2*`CPU_WORD_W-1:`CPU_WORD_W]
                                             : rot_r[`CPU_WORD_W-1:0];
            cpu_pkg::op_shf:
            begin
                if (left)
                begin
                    {carry_next, res_next} = shl;
                end
                else
                begin
                    res_next = op2 >> amt;  // right shift clears carry
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            result <= '0;
            carry  <= 1'b0;
        end
        else if (exec_strobe && cpu_pkg::is_alu_op(opcode))
        begin
            result <= res_next;
            carry  <= carry_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cpu_status.sv
`default_nettype none

`include "cpu_settings.svh"

module cpu_status (
    input  wire cpu_pkg::word_t result,
    input  wire logic           carry,
    input  wire cpu_pkg::cond_e cond,
    output cpu_pkg::flags_t     flags,
    output logic                branch_taken
);

    always_comb
    begin
        flags.zero     = (result == '0);
        flags.negative = result[`CPU_WORD_W-1];
        flags.even     = ~result[0];
        flags.parity   = ^result;              // odd number of ones
        flags.carry    = carry;
    end

    always_comb
    begin
        case (cond)
            cpu_pkg::cond_always:   branch_taken = 1'b1;
            cpu_pkg::cond_parity:   branch_taken = flags.parity;
            cpu_pkg::cond_even:     branch_taken = flags.even;
            cpu_pkg::cond_carry:    branch_taken = flags.carry;
            cpu_pkg::cond_negative: branch_taken = flags.negative;
            cpu_pkg::cond_zero:     branch_taken = flags.zero;
            cpu_pkg::cond_no_carry: branch_taken = ~flags.carry;
            cpu_pkg::cond_positive: branch_taken = ~(flags.negative | flags.zero);
            default:                branch_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/cpu_control.sv
`default_nettype none

`include "cpu_settings.svh"

module cpu_control (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire cpu_pkg::word_t    rdata,
    output cpu_pkg::mem_req_t      mem_req,
    output cpu_pkg::reg_idx_t      rd_idx_a,
    output cpu_pkg::reg_idx_t      rd_idx_b,
    input  wire cpu_pkg::word_t    rd_data_a,
    input  wire cpu_pkg::word_t    rd_data_b,
    output logic                   wr_en,
    output cpu_pkg::reg_idx_t      wr_idx,
    output cpu_pkg::word_t         wr_data,
    output cpu_pkg::word_t         op1,
    output cpu_pkg::word_t         op2,
    output cpu_pkg::opcode_e       opcode,
    output logic                   exec_strobe,
    input  wire cpu_pkg::word_t    alu_result,
    output cpu_pkg::cond_e         cond,
    input  wire logic              branch_taken
);

    cpu_pkg::stage_e stage;
    cpu_pkg::addr_t  pc;
    cpu_pkg::instr_t ir;
    cpu_pkg::addr_t  next_pc;
    logic            req_en;
    logic            req_write;
    cpu_pkg::addr_t  req_addr;
    cpu_pkg::word_t  req_wdata;

    assign opcode      = ir.opcode;
    assign cond        = ir.cond;
    assign rd_idx_a    = ir.addr_hi[`CPU_REG_IDX_W-1:0];  // source
    assign rd_idx_b    = ir.addr_lo[`CPU_REG_IDX_W-1:0];  // dest
    assign exec_strobe = (stage == cpu_pkg::st_execute);

    // branch_taken only matters for bra
    assign next_pc = (ir.opcode == cpu_pkg::op_bra && branch_taken) ? ir.addr_hi
                                                                    : pc + 1'b1;

    assign wr_en   = (stage == cpu_pkg::st_writeback) &&
                     (ir.opcode == cpu_pkg::op_ld || cpu_pkg::is_alu_op(ir.opcode));
    assign wr_idx  = ir.addr_lo[`CPU_REG_IDX_W-1:0];
    assign wr_data = (ir.opcode == cpu_pkg::op_ld) ? rdata : alu_result;

    assign mem_req = '{en: req_en, write: req_write, addr: req_addr, wdata: req_wdata};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stage     <= cpu_pkg::st_restart;
            pc        <= cpu_pkg::addr_t'(`CPU_RESET_PC);
            ir        <= '0;                      // nop, so the first writeback is idle
            req_en    <= 1'b0;
            req_write <= 1'b0;
        end
        else
        begin
            case (stage)
                cpu_pkg::st_restart:
                begin
                    req_en    <= 1'b1;            // fetch of the reset pc
                    req_write <= 1'b0;
                    stage     <= cpu_pkg::st_writeback;
                end
                cpu_pkg::st_fetch:
                begin
                    ir    <= cpu_pkg::instr_t'(rdata);
                    stage <= cpu_pkg::st_decode;
                end
                cpu_pkg::st_decode:
                begin
                    stage <= cpu_pkg::st_execute;
                end
                cpu_pkg::st_execute:
                begin
                    req_en    <= (ir.opcode == cpu_pkg::op_ld) ||
                                 (ir.opcode == cpu_pkg::op_str);
                    req_write <= (ir.opcode == cpu_pkg::op_str);
                    stage     <= (ir.opcode == cpu_pkg::op_hlt) ? cpu_pkg::st_halted
                                                                : cpu_pkg::st_memory;
                end
                cpu_pkg::st_memory:
                begin
                    pc        <= next_pc;
                    req_en    <= 1'b1;
                    req_write <= 1'b0;
                    stage     <= cpu_pkg::st_writeback;
                end
                cpu_pkg::st_writeback:
                begin
                    req_en <= 1'b0;
                    stage  <= cpu_pkg::st_fetch;
                end
                cpu_pkg::st_halted:
                begin
                    stage <= cpu_pkg::st_halted;  // only reset leaves
                end
                default:
                begin
                    stage <= cpu_pkg::st_restart;
                end
            endcase
        end
    end

    // operands and request payload
    always_ff @(posedge clk)
    begin
        if (stage == cpu_pkg::st_decode)
        begin
            op1 <= ir.cond[3] ? {{(`CPU_WORD_W-`CPU_ADDR_W){1'b0}}, ir.addr_hi} : rd_data_a;
            op2 <= ir.cond[2] ? '0 : rd_data_b;
        end
        case (stage)
            cpu_pkg::st_restart: req_addr <= pc;
            cpu_pkg::st_memory:  req_addr <= next_pc;
            cpu_pkg::st_execute:
            begin
                req_addr  <= (ir.opcode == cpu_pkg::op_str) ? ir.addr_lo : ir.addr_hi;
                req_wdata <= op1;                  // store data is operand 1
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/cpu_top.sv
`default_nettype none

module cpu_top (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire cpu_pkg::word_t    rdata,
    output cpu_pkg::mem_req_t      mem_req
);

    cpu_pkg::reg_idx_t rd_idx_a;
    cpu_pkg::reg_idx_t rd_idx_b;
    cpu_pkg::word_t    rd_data_a;
    cpu_pkg::word_t    rd_data_b;
    logic              wr_en;
    cpu_pkg::reg_idx_t wr_idx;
    cpu_pkg::word_t    wr_data;
    cpu_pkg::word_t    op1;
    cpu_pkg::word_t    op2;
    cpu_pkg::opcode_e  opcode;
    logic              exec_strobe;
    cpu_pkg::word_t    alu_result;
    logic              alu_carry;
    cpu_pkg::cond_e    cond;
    logic              branch_taken;

    cpu_control i_cpu_control (
        .clk          (clk),
        .reset        (reset),
        .rdata        (rdata),
        .mem_req      (mem_req),
        .rd_idx_a     (rd_idx_a),
        .rd_idx_b     (rd_idx_b),
        .rd_data_a    (rd_data_a),
        .rd_data_b    (rd_data_b),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_data      (wr_data),
        .op1          (op1),
        .op2          (op2),
        .opcode       (opcode),
        .exec_strobe  (exec_strobe),
        .alu_result   (alu_result),
        .cond         (cond),
        .branch_taken (branch_taken)
    );

    cpu_regfile i_cpu_regfile (
        .clk       (clk),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    cpu_alu i_cpu_alu (
        .clk         (clk),
        .reset       (reset),
        .exec_strobe (exec_strobe),
        .opcode      (opcode),
        .op1         (op1),
        .op2         (op2),
        .result      (alu_result),
        .carry       (alu_carry)
    );

    cpu_status i_cpu_status (
        .result       (alu_result),
        .carry        (alu_carry),
        .cond         (cond),
        .flags        (),              // only used for the branch decision
        .branch_taken (branch_taken)
    );

endmodule

`default_nettype wire

// File: dv/cpu_props.sv
`default_nettype none

module cpu_props (
    input wire logic              clk,
    input wire logic              reset,
    input wire cpu_pkg::mem_req_t mem_req,
    input wire cpu_pkg::stage_e   stage
);

    timeunit 1ns;
    timeprecision 1ps;

    // request register is cleared by reset
    a_no_req_in_reset: assert property (@(posedge clk) reset |=> !mem_req.en)
        else $error("memory request enabled after a reset cycle");

    // stores only show up in the memory stage
    a_write_in_memory: assert property (@(posedge clk) disable iff (reset)
        (mem_req.en && mem_req.write) |-> stage == cpu_pkg::st_memory)
        else $error("memory write outside the memory stage");

    a_halt_sticks: assert property (@(posedge clk) disable iff (reset)
        stage == cpu_pkg::st_halted |=> stage == cpu_pkg::st_halted)
        else $error("left the halted stage without reset");

endmodule

bind cpu_control cpu_props i_cpu_props (
    .clk     (clk),
    .reset   (reset),
    .mem_req (mem_req),
    .stage   (stage)
);

`default_nettype wire

// File: dv/cpu_tb.sv
`default_nettype none

`include "cpu_settings.svh"

module cpu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic              clk;
    logic              reset;
    cpu_pkg::word_t    rdata;
    cpu_pkg::mem_req_t mem_req;

    cpu_pkg::word_t mem [4096];
    cpu_pkg::word_t model_mem [4096];
    cpu_pkg::addr_t exp_read [$];
    cpu_pkg::addr_t exp_waddr [$];
    cpu_pkg::word_t exp_wdata [$];
    int             req_cycles [$];
    int             cyc;
    int             errors;
    int             test_errors;
    int             checks;
    int             tests;
    integer         seed;
    cpu_pkg::addr_t ptr;
    logic           rd_pending;
    cpu_pkg::addr_t rd_addr;

    cpu_top i_cpu_top (
        .clk     (clk),
        .reset   (reset),
        .rdata   (rdata),
        .mem_req (mem_req)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // memory model, a read returns its data in the next cycle and holds it
    always @(negedge clk)
    begin
        if (rd_pending)
            rdata = mem[rd_addr];
        rd_pending = 1'b0;
        if (!reset && mem_req.en === 1'b1)
        begin
            if (mem_req.write)
                mem[mem_req.addr] = mem_req.wdata;
            else
            begin
                rd_pending = 1'b1;
                rd_addr    = mem_req.addr;
            end
        end
    end

    task automatic check_word(input string name, input cpu_pkg::word_t exp,
                              input cpu_pkg::word_t act);
        checks++;
        if (exp !== act)
        begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_addr(input string name, input cpu_pkg::addr_t exp,
                              input cpu_pkg::addr_t act);
        checks++;
        if (exp !== act)
        begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_gap(input string name, input int exp, input int act);
        checks++;
        if (exp != act)
        begin
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        errors++;
        test_errors++;
    endtask

    // compares every bus request with the model sequence
    always @(negedge clk)
    begin
        cyc++;
        if (reset)
        begin
            if (mem_req.en === 1'b1)
                report_problem("memory request enabled while reset is high");
        end
        else if (mem_req.en === 1'b1)
        begin
            req_cycles.push_back(cyc);
            if (mem_req.write)
            begin
                if (exp_waddr.size() == 0)
                    report_problem("store seen when no store was expected");
                else
                begin
                    check_addr("store address", exp_waddr.pop_front(), mem_req.addr);
                    check_word("store data", exp_wdata.pop_front(), mem_req.wdata);
                end
            end
            else if (exp_read.size() == 0)
                report_problem("read seen when no read was expected");
            else
                check_addr("read address", exp_read.pop_front(), mem_req.addr);
        end
    end

    function automatic logic branch_expected(input logic [3:0] cnd, input cpu_pkg::word_t r,
                                             input logic c);
        logic t;
        case (cnd)
            4'd0: t = 1'b1;
            4'd1: t = ^r;
            4'd2: t = !r[0];
            4'd3: t = c;
            4'd4: t = r[31];
            4'd5: t = (r == 32'd0);
            4'd6: t = !c;
            4'd7: t = !r[31] && (r != 32'd0);
            default: t = 1'b0;
        endcase
        return t;
    endfunction

    // ISA level run of model_mem, fills the expected request queues
    function automatic void cpu_model();
        cpu_pkg::word_t regs [16];
        cpu_pkg::word_t res;
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        cpu_pkg::addr_t pc;
        cpu_pkg::instr_t ins;
        logic           carry;
        logic [3:0]     amt;
        logic           halted;
        int             step;
        exp_read.delete();
        exp_waddr.delete();
        exp_wdata.delete();
        foreach (regs[i])
            regs[i] = '0;
        res = '0;
        carry = 1'b0;
        halted = 1'b0;
        pc = 12'd`CPU_RESET_PC;
        exp_read.push_back(pc);
        for (step = 0; step < 2000 && !halted; step++)
        begin
            ins = cpu_pkg::instr_t'(model_mem[pc]);
            a = ins.cond[3] ? {20'd0, ins.addr_hi} : regs[ins.addr_hi[3:0]];
            b = ins.cond[2] ? 32'd0 : regs[ins.addr_lo[3:0]];
            amt = a[3:0];
            pc = pc + 12'd1;
            case (ins.opcode)
                cpu_pkg::op_ld:
                begin
                    exp_read.push_back(ins.addr_hi);
                    regs[ins.addr_lo[3:0]] = model_mem[ins.addr_hi];
                end
                cpu_pkg::op_str:
                begin
                    exp_waddr.push_back(ins.addr_lo);
                    exp_wdata.push_back(a);
                    model_mem[ins.addr_lo] = a;
                end
                cpu_pkg::op_bra:
                    if (branch_expected(ins.cond, res, carry))
                        pc = ins.addr_hi;
                cpu_pkg::op_xor: {carry, res} = {1'b0, a ^ b};
                cpu_pkg::op_add: {carry, res} = {1'b0, a} + {1'b0, b};
                cpu_pkg::op_cmp: {carry, res} = {1'b0, 32'd0 - a};
                cpu_pkg::op_rot:
                begin
                    carry = 1'b0;
                    if (amt == 4'd0)
                        res = b;
                    else if (a[4])
                        res = (b << amt) | (b >> (6'd32 - amt));
                    else
                        res = (b >> amt) | (b << (6'd32 - amt));
                end
                cpu_pkg::op_shf:
                begin
                    res = a[4] ? b << amt : b >> amt;
                    carry = (a[4] && amt != 4'd0) ? b[6'd32 - amt] : 1'b0;
                end
                cpu_pkg::op_hlt: halted = 1'b1;
                default: ;
            endcase
            if (ins.opcode inside {cpu_pkg::op_xor, cpu_pkg::op_add, cpu_pkg::op_rot,
                                   cpu_pkg::op_shf, cpu_pkg::op_cmp})
                regs[ins.addr_lo[3:0]] = res;
            if (!halted)
                exp_read.push_back(pc);
        end
    endfunction

    function automatic cpu_pkg::word_t enc(input logic [3:0] op, input logic [3:0] cnd,
                                           input cpu_pkg::addr_t hi, input cpu_pkg::addr_t lo);
        return {op, cnd, hi, lo};
    endfunction

    task automatic put(input cpu_pkg::word_t w);
        mem[ptr] = w;
        ptr = ptr + 12'd1;
    endtask

    task automatic new_program();
        for (int i = 0; i < 4096; i++)
            mem[i] = 32'hc0de_0000 | i;  // opcode 12 runs as nop
        mem[12'h100] = 32'hffff_ffff;
        mem[12'h101] = 32'h8000_0001;
        mem[12'h102] = 32'h1234_5678;
        mem[12'h103] = 32'h8000_0000;
        ptr = 12'd`CPU_RESET_PC;
    endtask

    task automatic run_test(input string name);
        int t;
        model_mem = mem;
        cpu_model();
        test_errors = 0;
        @(negedge clk);
        reset = 1'b1;
        repeat (3) @(negedge clk);
        req_cycles.delete();
        reset = 1'b0;
        t = 0;
        while ((exp_read.size() != 0 || exp_waddr.size() != 0) && t < 5000)
        begin
            @(negedge clk);
            t++;
        end
        if (t >= 5000)
            report_problem($sformatf("timeout, %s never finished its requests", name));
        else
            repeat (50) @(negedge clk);    // halted, any request is flagged
        tests++;
        $display("test %s done with %0d errors", name, test_errors);
    endtask

    initial
    begin
        cpu_pkg::word_t w;
        int             n;
        int             amts [4];
        amts = '{0, 1, 4, 15};
        seed = 32'had65;
        reset = 1'b1;
        rdata = '0;
        rd_pending = 1'b0;
        rd_addr = '0;
        cyc = 0;
        errors = 0;
        checks = 0;
        tests = 0;

        new_program();
        put(enc(cpu_pkg::op_nop, 4'd0, 12'd0, 12'd0));
        put(enc(cpu_pkg::op_nop, 4'd0, 12'd0, 12'd0));
        put(enc(cpu_pkg::op_hlt, 4'd0, 12'd0, 12'd0));
        run_test("boot");
        check_gap("boot request gap", 5, req_cycles[1] - req_cycles[0]);

        new_program();
        put(enc(cpu_pkg::op_ld, 4'd0, 12'h100, 12'd1));
        put(enc(cpu_pkg::op_ld, 4'd0, 12'h101, 12'd2));
        put(enc(cpu_pkg::op_ld, 4'd0, 12'h102, 12'd3));
        put(enc(cpu_pkg::op_xor, 4'd0, 12'd3, 12'd2));
        put(enc(cpu_pkg::op_str, 4'd0, 12'd2, 12'h200));
        put(enc(cpu_pkg::op_add, 4'd0, 12'd3, 12'd1));   // carries out
        put(enc(cpu_pkg::op_str, 4'd0, 12'd1, 12'h201));
        put(enc(cpu_pkg::op_cmp, 4'd0, 12'd3, 12'd4));
        put(enc(cpu_pkg::op_str, 4'd0, 12'd4, 12'h202));
        put(enc(cpu_pkg::op_add, 4'b1000, 12'h7ff, 12'd4));
        put(enc(cpu_pkg::op_str, 4'd0, 12'd4, 12'h203));
        put(enc(cpu_pkg::op_add, 4'b1100, 12'h055, 12'd5));
        put(enc(cpu_pkg::op_str, 4'd0, 12'd5, 12'h204));
        put(enc(cpu_pkg::op_hlt, 4'd0, 12'd0, 12'd0));
        run_test("load_alu_store");

        new_program();
        n = 0;
        for (int op = 6; op < 8; op++)
            for (int d = 0; d < 2; d++)
                for (int k = 0; k < 4; k++)
                begin
                    put(enc(cpu_pkg::op_ld, 4'd0, 12'h102, 12'd2));
                    put(enc(op[3:0], 4'b1000, cpu_pkg::addr_t'(d * 16 + amts[k]), 12'd2));
                    put(enc(cpu_pkg::op_str, 4'd0, 12'd2, 12'h200 + cpu_pkg::addr_t'(n)));
                    n++;
                end
        put(enc(cpu_pkg::op_ld, 4'd0, 12'h101, 12'd2));
        put(enc(cpu_pkg::op_shf, 4'b1000, 12'h011, 12'd2));  // loses bit 31
        put(enc(cpu_pkg::op_bra, cpu_pkg::cond_carry, ptr + 12'd2, 12'd0));
        put(enc(cpu_pkg::op_hlt, 4'd0, 12'd0, 12'd0));
        put(enc(cpu_pkg::op_str, 4'd0, 12'd2, 12'h220));
        put(enc(cpu_pkg::op_hlt, 4'd0, 12'd0, 12'd0));
        run_test("rotate_shift");

        new_program();
        put(enc(cpu_pkg::op_ld, 4'd0, 12'h103, 12'd2));
        for (int s = 0; s < 3; s++)
        begin
            if (s == 0)
                put(enc(cpu_pkg::op_xor, 4'b1100, 12'd0, 12'd6));   // zero, even
            else if (s == 1)
            begin
                put(enc(cpu_pkg::op_ld, 4'd0, 12'h100, 12'd7));
                put(enc(cpu_pkg::op_add, 4'd0, 12'd2, 12'd7));      // carry, positive
            end
            else
                put(enc(cpu_pkg::op_cmp, 4'b1000, 12'd1, 12'd8));   // negative
            for (int c = 0; c < 9; c++)
            begin
                put(enc(cpu_pkg::op_bra, c[3:0], ptr + 12'd2, 12'd0));
                put(enc(cpu_pkg::op_nop, 4'd0, 12'd0, 12'd0));
            end
        end
        put(enc(cpu_pkg::op_hlt, 4'd0, 12'd0, 12'd0));
        run_test("branches");

        new_program();
        put(enc(cpu_pkg::op_hlt, 4'd0, 12'd0, 12'd0));
        run_test("halt");
        run_test("halt_restart");

        new_program();
        for (int i = 0; i < 8; i++)
        begin
            w = $random(seed);
            mem[12'h100 + i] = w;
            put(enc(cpu_pkg::op_ld, 4'd0, 12'h100 + cpu_pkg::addr_t'(i), cpu_pkg::addr_t'(i)));
        end
        for (int i = 0; i < 40; i++)
        begin
            w = $random(seed);
            case (w[2:0])
                3'd0:    n = 4;
                3'd1:    n = 5;
                3'd2:    n = 6;
                3'd3:    n = 7;
                default: n = 9;
            endcase
            put(enc(n[3:0], {w[4:3], 2'b00}, {w[15:12], 5'd0, w[7:5]}, {9'd0, w[10:8]}));
            put(enc(cpu_pkg::op_str, 4'd0, {9'd0, w[10:8]}, 12'h300 + cpu_pkg::addr_t'(i)));
        end
        put(enc(cpu_pkg::op_hlt, 4'd0, 12'd0, 12'd0));
        run_test("random");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/cpu_regfile.sv
hdl/cpu_alu.sv
hdl/cpu_status.sv
hdl/cpu_control.sv
hdl/cpu_top.sv
dv/cpu_props.sv
dv/cpu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the cpu testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -f compile.f --top-module cpu_tb \
    --Mdir "$BUILD" -o sim_cpu
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD/sim_cpu" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with no errors" "$LOG"; then
    exit 0
fi
echo "simulation reported failures, see $LOG"
exit 1
